// File: logic/axi3_conv_pkg.sv
`default_nettype none

package axi3_conv_pkg;

  // AXI response codes, shared by both sides of the converter
  typedef enum logic [1:0] {
    resp_okay   = 2'b00,
    resp_exokay = 2'b01,
    resp_slverr = 2'b10,
    resp_decerr = 2'b11
  } axi_resp_e;

  // burst type as carried on ARBURST
  typedef enum logic [1:0] {
    burst_fixed = 2'b00,
    burst_incr  = 2'b01,
    burst_wrap  = 2'b10
  } axi_burst_e;

  // address splitter FSM
  typedef enum logic {
    split_idle  = 1'b0,
    split_issue = 1'b1
  } split_state_e;

  // longest burst an AXI3 slave accepts
  localparam int axi3_max_beats = 16;

endpackage

`default_nettype wire

// File: logic/ar_axi3_split.sv
`timescale 1ns/10ps
`default_nettype none

module ar_axi3_split #(
  parameter int id_width   = 4,
  parameter int addr_width = 32,
  parameter int data_width = 32
) (
  input  wire logic                        aclk,
  input  wire logic                        rst,

  // AXI4 read address from the master
  input  wire logic [id_width-1:0]         s_arid,
  input  wire logic [addr_width-1:0]       s_araddr,
  input  wire logic [7:0]                  s_arlen,
  input  wire axi3_conv_pkg::axi_burst_e   s_arburst,
  input  wire logic                        s_arvalid,
  output logic                             s_arready,

  // AXI3 read address towards the slave
  output logic [id_width-1:0]              m_arid,
  output logic [addr_width-1:0]            m_araddr,
  output logic [3:0]                       m_arlen,
  output axi3_conv_pkg::axi_burst_e        m_arburst,
  output logic                             m_arvalid,
  input  wire logic                        m_arready,

  // command queue write side
  input  wire logic                        cmd_full,
  output logic                             cmd_push,
  output logic                             cmd_split_in
);

  localparam logic [8:0] max_beats = 9'(axi3_conv_pkg::axi3_max_beats);
  localparam int beat_bytes = data_width / 8;
  // byte distance between the start addresses of two INCR pieces
  localparam logic [addr_width-1:0] piece_bytes =
    addr_width'(axi3_conv_pkg::axi3_max_beats * beat_bytes);

  axi3_conv_pkg::split_state_e state;

  // beats still to be issued, current piece included
  logic [8:0] remain_q;
  logic [8:0] remain_next;
  logic       s_ar_hs;
  logic       m_ar_hs;
  logic       last_piece;

  // AXI3 ARLEN for a piece that starts with the given number of beats left
  function automatic logic [3:0] piece_len(input logic [8:0] beats);
    logic [8:0] len;
    if (beats > max_beats) begin
      len = max_beats - 9'd1;
    end else begin
      len = beats - 9'd1;
    end
    return len[3:0];
  endfunction

  assign s_ar_hs     = s_arvalid && s_arready;
  assign m_ar_hs     = m_arvalid && m_arready;
  assign last_piece  = (remain_q <= max_beats);
  assign remain_next = remain_q - max_beats;

  // no new piece goes out while the queue cannot take its command
  assign m_arvalid    = (state == axi3_conv_pkg::split_issue) && !cmd_full;
  assign cmd_push     = m_ar_hs;
  assign cmd_split_in = !last_piece;

  always_ff @(posedge aclk) begin
    if (rst) begin
      state     <= axi3_conv_pkg::split_idle;
      s_arready <= 1'b0;
      remain_q  <= '0;
    end else begin
      case (state)
        axi3_conv_pkg::split_idle: begin
          if (s_ar_hs) begin
            state     <= axi3_conv_pkg::split_issue;
            s_arready <= 1'b0;
            remain_q  <= {1'b0, s_arlen} + 9'd1;
          end else begin
            s_arready <= 1'b1;
          end
        end
        axi3_conv_pkg::split_issue: begin
          if (m_ar_hs) begin
            if (last_piece) begin
              state     <= axi3_conv_pkg::split_idle;
              s_arready <= 1'b1;
            end else begin
              remain_q <= remain_next;
            end
          end
        end
        default: begin
          state     <= axi3_conv_pkg::split_idle;
          s_arready <= 1'b0;
        end
      endcase
    end
  end

  // address payload of the piece on offer
  always_ff @(posedge aclk) begin
    if (s_ar_hs) begin
      m_arid    <= s_arid;
      m_araddr  <= s_araddr;
      m_arburst <= s_arburst;
      m_arlen   <= piece_len({1'b0, s_arlen} + 9'd1);
    end else if (m_ar_hs && !last_piece) begin
      m_arlen <= piece_len(remain_next);
      // FIXED pieces keep hitting the same address
      if (m_arburst == axi3_conv_pkg::burst_incr) begin
        m_araddr <= m_araddr + piece_bytes;
      end
    end
  end

endmodule

`default_nettype wire

// File: logic/split_cmd_fifo.sv
`timescale 1ns/10ps
`default_nettype none

module split_cmd_fifo #(
  parameter int cmd_depth = 4
) (
  input  wire logic aclk,
  input  wire logic rst,

  // write side, from the address splitter
  input  wire logic cmd_push,
  input  wire logic cmd_split_in,
  output logic      cmd_full,

  // read side, to the read data merge
  output logic      cmd_valid,
  output logic      cmd_split,
  input  wire logic cmd_ready
);

  localparam int ptr_width = $clog2(cmd_depth);

  // one split flag per outstanding AXI3 piece
  logic [cmd_depth-1:0] mem;
  logic [ptr_width-1:0] wr_ptr;
  logic [ptr_width-1:0] rd_ptr;
  logic [ptr_width:0]   count;
  logic                 pop;

  assign pop = cmd_valid && cmd_ready;

  assign cmd_valid = (count != '0);
  assign cmd_split = mem[rd_ptr];
  // a pop in this cycle already makes room for the next push
  assign cmd_full  = (count == (ptr_width + 1)'(cmd_depth)) && !pop;

  always_ff @(posedge aclk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (cmd_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if (cmd_push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !cmd_push) begin
        count <= count - 1'b1;
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (cmd_push) begin
      mem[wr_ptr] <= cmd_split_in;
    end
  end

endmodule

`default_nettype wire

// File: logic/r_axi3_merge.sv
`timescale 1ns/10ps
`default_nettype none

module r_axi3_merge #(
  parameter int id_width   = 4,
  parameter int data_width = 32
) (
  // command queue read side
  input  wire logic                       cmd_valid,
  input  wire logic                       cmd_split,
  output logic                            cmd_ready,

  // AXI3 read data from the slave
  input  wire logic [id_width-1:0]        m_rid,
  input  wire logic [data_width-1:0]      m_rdata,
  input  wire axi3_conv_pkg::axi_resp_e   m_rresp,
  input  wire logic                       m_rlast,
  input  wire logic                       m_rvalid,
  output logic                            m_rready,

  // AXI4 read data to the master
  output logic [id_width-1:0]             s_rid,
  output logic [data_width-1:0]           s_rdata,
  output axi3_conv_pkg::axi_resp_e        s_rresp,
  output logic                            s_rlast,
  output logic                            s_rvalid,
  input  wire logic                       s_rready
);

  logic si_stalling;
  logic beat_taken;

  // beats only flow while the piece they belong to is known
  assign s_rvalid    = m_rvalid && cmd_valid;
  assign si_stalling = s_rvalid && !s_rready;
  assign m_rready    = cmd_valid && !si_stalling;

  assign beat_taken = s_rvalid && s_rready;

  // end of an AXI3 piece retires its command
  assign cmd_ready = cmd_valid && beat_taken && m_rlast;

  // the master only sees RLAST of the final piece
  assign s_rlast = m_rlast && !cmd_split;

  assign s_rid   = m_rid;
  assign s_rdata = m_rdata;
  assign s_rresp = m_rresp;

endmodule

`default_nettype wire

// File: logic/axi4_to_axi3_rd_conv.sv
`timescale 1ns/10ps
`default_nettype none

module axi4_to_axi3_rd_conv #(
  parameter int id_width   = 4,
  parameter int addr_width = 32,
  parameter int data_width = 32,
  parameter int cmd_depth  = 4
) (
  input  wire logic                       aclk,
  input  wire logic                       rst,

  // AXI4 slave side, read address
  input  wire logic [id_width-1:0]        s_arid,
  input  wire logic [addr_width-1:0]      s_araddr,
  input  wire logic [7:0]                 s_arlen,
  input  wire axi3_conv_pkg::axi_burst_e  s_arburst,
  input  wire logic                       s_arvalid,
  output logic                            s_arready,

  // AXI4 slave side, read data
  output logic [id_width-1:0]             s_rid,
  output logic [data_width-1:0]           s_rdata,
  output axi3_conv_pkg::axi_resp_e        s_rresp,
  output logic                            s_rlast,
  output logic                            s_rvalid,
  input  wire logic                       s_rready,

  // AXI3 master side, read address
  output logic [id_width-1:0]             m_arid,
  output logic [addr_width-1:0]           m_araddr,
  output logic [3:0]                      m_arlen,
  output axi3_conv_pkg::axi_burst_e       m_arburst,
  output logic                            m_arvalid,
  input  wire logic                       m_arready,

  // AXI3 master side, read data
  input  wire logic [id_width-1:0]        m_rid,
  input  wire logic [data_width-1:0]      m_rdata,
  input  wire axi3_conv_pkg::axi_resp_e   m_rresp,
  input  wire logic                       m_rlast,
  input  wire logic                       m_rvalid,
  output logic                            m_rready
);

  logic cmd_push;
  logic cmd_split_in;
  logic cmd_full;
  logic cmd_valid;
  logic cmd_split;
  logic cmd_ready;

  ar_axi3_split #(
    .id_width   (id_width),
    .addr_width (addr_width),
    .data_width (data_width)
  ) i_split (
    .aclk         (aclk),
    .rst          (rst),
    .s_arid       (s_arid),
    .s_araddr     (s_araddr),
    .s_arlen      (s_arlen),
    .s_arburst    (s_arburst),
    .s_arvalid    (s_arvalid),
    .s_arready    (s_arready),
    .m_arid       (m_arid),
    .m_araddr     (m_araddr),
    .m_arlen      (m_arlen),
    .m_arburst    (m_arburst),
    .m_arvalid    (m_arvalid),
    .m_arready    (m_arready),
    .cmd_full     (cmd_full),
    .cmd_push     (cmd_push),
    .cmd_split_in (cmd_split_in)
  );

  // one entry per AXI3 piece in flight
  split_cmd_fifo #(
    .cmd_depth (cmd_depth)
  ) i_cmd_fifo (
    .aclk         (aclk),
    .rst          (rst),
    .cmd_push     (cmd_push),
    .cmd_split_in (cmd_split_in),
    .cmd_full     (cmd_full),
    .cmd_valid    (cmd_valid),
    .cmd_split    (cmd_split),
    .cmd_ready    (cmd_ready)
  );

  r_axi3_merge #(
    .id_width   (id_width),
    .data_width (data_width)
  ) i_merge (
    .cmd_valid (cmd_valid),
    .cmd_split (cmd_split),
    .cmd_ready (cmd_ready),
    .m_rid     (m_rid),
    .m_rdata   (m_rdata),
    .m_rresp   (m_rresp),
    .m_rlast   (m_rlast),
    .m_rvalid  (m_rvalid),
    .m_rready  (m_rready),
    .s_rid     (s_rid),
    .s_rdata   (s_rdata),
    .s_rresp   (s_rresp),
    .s_rlast   (s_rlast),
    .s_rvalid  (s_rvalid),
    .s_rready  (s_rready)
  );

endmodule

`default_nettype wire

// File: tb/axi3_rd_slave.sv
`timescale 1ns/10ps
`default_nettype none

module axi3_rd_slave #(
  parameter int id_width   = 4,
  parameter int addr_width = 32,
  parameter int data_width = 32
) (
  input  wire logic                       aclk,
  input  wire logic                       rst,
  input  wire logic [id_width-1:0]        m_arid,
  input  wire logic [addr_width-1:0]      m_araddr,
  input  wire logic [3:0]                 m_arlen,
  input  wire axi3_conv_pkg::axi_burst_e  m_arburst,
  input  wire logic                       m_arvalid,
  output logic                            m_arready,
  output logic [id_width-1:0]             m_rid,
  output logic [data_width-1:0]           m_rdata,
  output axi3_conv_pkg::axi_resp_e        m_rresp,
  output logic                            m_rlast,
  output logic                            m_rvalid,
  input  wire logic                       m_rready
);

  localparam int beat_bytes = data_width / 8;

  // accepted pieces waiting for their data
  logic [id_width-1:0]       pend_id[$];
  logic [addr_width-1:0]     pend_addr[$];
  logic [3:0]                pend_len[$];
  axi3_conv_pkg::axi_burst_e pend_burst[$];
  int                        beat;
  logic                      ar_hs;
  logic                      r_hs;

  initial begin
    m_arready = 1'b0;
    m_rvalid  = 1'b0;
    m_rid     = '0;
    m_rdata   = '0;
    m_rresp   = axi3_conv_pkg::resp_okay;
    m_rlast   = 1'b0;
    beat      = 0;
    forever begin
      @(posedge aclk);
      ar_hs = m_arvalid && m_arready;
      r_hs  = m_rvalid && m_rready;
      if (rst) begin
        pend_id.delete();
        pend_addr.delete();
        pend_len.delete();
        pend_burst.delete();
        beat = 0;
      end else begin
        if (r_hs && m_rlast) begin
          void'(pend_id.pop_front());
          void'(pend_addr.pop_front());
          void'(pend_len.pop_front());
          void'(pend_burst.pop_front());
          beat = 0;
        end else if (r_hs) begin
          beat++;
        end
        if (ar_hs) begin
          pend_id.push_back(m_arid);
          pend_addr.push_back(m_araddr);
          pend_len.push_back(m_arlen);
          pend_burst.push_back(m_arburst);
        end
      end
      #1;
      m_arready = !rst && ($urandom_range(3) != 0);
      if (rst) begin
        m_rvalid = 1'b0;
      end else if (!m_rvalid || r_hs) begin
        // random gaps between beats
        m_rvalid = (pend_addr.size() != 0) && ($urandom_range(3) != 0);
        if (m_rvalid) begin
          m_rid = pend_id[0];
          if (pend_burst[0] == axi3_conv_pkg::burst_fixed) begin
            m_rdata = data_width'(pend_addr[0]);
          end else begin
            m_rdata = data_width'(pend_addr[0] + addr_width'(beat * beat_bytes));
          end
          if (pend_addr[0] >= 'hE000 && pend_addr[0] <= 'hEFFF) begin
            m_rresp = axi3_conv_pkg::resp_slverr;
          end else begin
            m_rresp = axi3_conv_pkg::resp_okay;
          end
          m_rlast = (beat == int'(pend_len[0]));
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: tb/axi3_conv_assertions.sv
`timescale 1ns/10ps
`default_nettype none

module axi3_conv_assertions #(
  parameter int addr_width = 32,
  parameter int data_width = 32
) (
  input wire logic                  aclk,
  input wire logic                  rst,
  input wire logic [addr_width-1:0] m_araddr,
  input wire logic [3:0]            m_arlen,
  input wire logic                  m_arvalid,
  input wire logic                  m_arready,
  input wire logic                  cmd_split_in,
  input wire logic                  s_arready,
  input wire logic [data_width-1:0] s_rdata,
  input wire logic                  s_rlast,
  input wire logic                  s_rvalid,
  input wire logic                  s_rready
);

  int assert_fails = 0;

  // every piece ahead of the last one carries a full AXI3 burst
  arlen_limit: assert property (@(posedge aclk) disable iff (rst)
    m_arvalid && cmd_split_in |-> (int'(m_arlen) + 1 == axi3_conv_pkg::axi3_max_beats))
    else begin
      $error("m_arlen 0x%0h is short of the AXI3 burst limit on a non-final piece", m_arlen);
      assert_fails++;
    end

  ar_stable: assert property (@(posedge aclk) disable iff (rst)
    m_arvalid && !m_arready |=> m_arvalid && $stable(m_araddr) && $stable(m_arlen))
    else begin
      $error("AXI3 read address changed or dropped before its handshake");
      assert_fails++;
    end

  // a stalled beat keeps its payload towards the master
  r_stable: assert property (@(posedge aclk) disable iff (rst)
    s_rvalid && !s_rready |=> s_rvalid && $stable(s_rdata) && $stable(s_rlast))
    else begin
      $error("AXI4 read beat changed or dropped before its handshake");
      assert_fails++;
    end

  reset_quiet: assert property (@(posedge aclk)
    rst |=> !s_arready && !m_arvalid && !s_rvalid)
    else begin
      $error("handshake output active right after reset");
      assert_fails++;
    end

endmodule

bind axi4_to_axi3_rd_conv axi3_conv_assertions #(
  .addr_width (addr_width),
  .data_width (data_width)
) i_assert (.*);

`default_nettype wire

// File: tb/tb_axi4_to_axi3_rd_conv.sv
`timescale 1ns/10ps
`default_nettype none

module tb_axi4_to_axi3_rd_conv;

  localparam int id_width   = 4;
  localparam int addr_width = 32;
  localparam int data_width = 32;
  localparam int cmd_depth  = 4;
  localparam int beat_bytes = data_width / 8;
  // about 700 beats in all at a few cycles each, with a wide margin
  localparam int timeout_cycles = 20000;

  logic                      aclk;
  logic                      rst;
  logic [id_width-1:0]       s_arid;
  logic [addr_width-1:0]     s_araddr;
  logic [7:0]                s_arlen;
  axi3_conv_pkg::axi_burst_e s_arburst;
  logic                      s_arvalid;
  logic                      s_arready;
  logic [id_width-1:0]       s_rid;
  logic [data_width-1:0]     s_rdata;
  axi3_conv_pkg::axi_resp_e  s_rresp;
  logic                      s_rlast;
  logic                      s_rvalid;
  logic                      s_rready;
  logic [id_width-1:0]       m_arid;
  logic [addr_width-1:0]     m_araddr;
  logic [3:0]                m_arlen;
  axi3_conv_pkg::axi_burst_e m_arburst;
  logic                      m_arvalid;
  logic                      m_arready;
  logic [id_width-1:0]       m_rid;
  logic [data_width-1:0]     m_rdata;
  axi3_conv_pkg::axi_resp_e  m_rresp;
  logic                      m_rlast;
  logic                      m_rvalid;
  logic                      m_rready;

  // expected traffic, in issue order
  logic [id_width-1:0]       exp_ar_id[$];
  logic [addr_width-1:0]     exp_ar_addr[$];
  logic [3:0]                exp_ar_len[$];
  axi3_conv_pkg::axi_burst_e exp_ar_burst[$];
  logic [id_width-1:0]       exp_r_id[$];
  logic [data_width-1:0]     exp_r_data[$];
  axi3_conv_pkg::axi_resp_e  exp_r_resp[$];
  logic                      exp_r_last[$];
  int                        cycle_count;
  int                        rlast_count;
  logic                      saw_full;
  logic                      random_rready;

  axi4_to_axi3_rd_conv #(
    .id_width   (id_width),
    .addr_width (addr_width),
    .data_width (data_width),
    .cmd_depth  (cmd_depth)
  ) i_dut (.*);

  axi3_rd_slave #(
    .id_width   (id_width),
    .addr_width (addr_width),
    .data_width (data_width)
  ) i_slave (.*);

  initial begin
    aclk = 1'b0;
    forever #5 aclk = ~aclk;
  end

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Simulation failed");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
    assert (got == exp)
      else abort_run($sformatf("FAIL %s: got 0x%0h, expected 0x%0h", name, got, exp));
  endtask

  // split rule and slave data rule applied to one AXI4 read
  function automatic void expect_read(input logic [id_width-1:0] id,
      input logic [addr_width-1:0] addr, input logic [7:0] len,
      input axi3_conv_pkg::axi_burst_e burst);
    int                    left;
    int                    piece;
    logic [addr_width-1:0] pa;
    left = int'(len) + 1;
    pa   = addr;
    while (left > 0) begin
      piece = (left > axi3_conv_pkg::axi3_max_beats) ? axi3_conv_pkg::axi3_max_beats : left;
      exp_ar_id.push_back(id);
      exp_ar_addr.push_back(pa);
      exp_ar_len.push_back(4'(piece - 1));
      exp_ar_burst.push_back(burst);
      for (int j = 0; j < piece; j++) begin
        exp_r_id.push_back(id);
        if (burst == axi3_conv_pkg::burst_fixed) begin
          exp_r_data.push_back(data_width'(pa));
        end else begin
          exp_r_data.push_back(data_width'(pa + addr_width'(j * beat_bytes)));
        end
        if (pa >= 'hE000 && pa <= 'hEFFF) begin
          exp_r_resp.push_back(axi3_conv_pkg::resp_slverr);
        end else begin
          exp_r_resp.push_back(axi3_conv_pkg::resp_okay);
        end
        exp_r_last.push_back(j == piece - 1 && left == piece);
      end
      left -= piece;
      if (burst == axi3_conv_pkg::burst_incr) begin
        pa += addr_width'(axi3_conv_pkg::axi3_max_beats * beat_bytes);
      end
    end
  endfunction

  task automatic issue_read(input logic [id_width-1:0] id, input logic [addr_width-1:0] addr,
      input logic [7:0] len, input axi3_conv_pkg::axi_burst_e burst);
    expect_read(id, addr, len, burst);
    @(posedge aclk);
    #1;
    s_arid    = id;
    s_araddr  = addr;
    s_arlen   = len;
    s_arburst = burst;
    s_arvalid = 1'b1;
    do @(posedge aclk); while (!s_arready);
    #1;
    s_arvalid = 1'b0;
  endtask

  task automatic wait_done();
    while (exp_r_data.size() != 0 || exp_ar_addr.size() != 0) @(negedge aclk);
  endtask

  task automatic check_ar();
    assert (exp_ar_addr.size() != 0)
      else abort_run("AXI3 read address issued with no piece expected");
    check_value("m_arid", m_arid, exp_ar_id.pop_front());
    check_value("m_araddr", m_araddr, exp_ar_addr.pop_front());
    check_value("m_arlen", m_arlen, exp_ar_len.pop_front());
    check_value("m_arburst", m_arburst, exp_ar_burst.pop_front());
  endtask

  task automatic check_r();
    assert (exp_r_data.size() != 0)
      else abort_run("AXI4 read beat delivered with no beat expected");
    check_value("s_rid", s_rid, exp_r_id.pop_front());
    check_value("s_rdata", s_rdata, exp_r_data.pop_front());
    check_value("s_rresp", s_rresp, exp_r_resp.pop_front());
    check_value("s_rlast", s_rlast, exp_r_last.pop_front());
    if (s_rlast) begin
      rlast_count++;
    end
  endtask

  always @(posedge aclk) begin
    if (!rst && m_arvalid && m_arready) begin
      check_ar();
    end
    if (!rst && s_rvalid && s_rready) begin
      check_r();
    end
    if (i_dut.cmd_full) begin
      saw_full = 1'b1;
    end
  end

  always @(negedge aclk) begin
    assert (i_dut.i_assert.assert_fails == 0)
      else abort_run("a protocol assertion on the DUT ports failed");
  end

  always @(posedge aclk) begin
    cycle_count++;
    if (cycle_count >= timeout_cycles) begin
      abort_run($sformatf("run did not finish within %0d cycles", timeout_cycles));
    end
  end

  // master side ready, random gaps only when enabled
  initial begin
    s_rready = 1'b0;
    forever begin
      @(posedge aclk);
      #1;
      s_rready = random_rready ? ($urandom_range(2) != 0) : 1'b1;
    end
  end

  task automatic test_short_incr();
    issue_read(4'h3, 32'h0000_1000, 8'd7, axi3_conv_pkg::burst_incr);
    wait_done();
    check_value("rlast_count", rlast_count, 1);
  endtask

  task automatic test_long_incr();
    issue_read(4'h5, 32'h0000_2000, 8'd63, axi3_conv_pkg::burst_incr);
    wait_done();
    check_value("rlast_count", rlast_count, 2);
  endtask

  task automatic test_incr_then_fixed();
    issue_read(4'h6, 32'h0000_3000, 8'd19, axi3_conv_pkg::burst_incr);
    issue_read(4'h7, 32'h0000_4000, 8'd39, axi3_conv_pkg::burst_fixed);
    wait_done();
    check_value("rlast_count", rlast_count, 4);
  endtask

  task automatic test_backpressure();
    random_rready = 1'b1;
    issue_read(4'h9, 32'h0000_8000, 8'd255, axi3_conv_pkg::burst_incr);
    wait_done();
    saw_full = 1'b0;
    for (int i = 0; i < 4; i++) begin
      issue_read(4'(4'hA + i), 32'h0000_9000 + 32'(i * 'h100), 8'd63, axi3_conv_pkg::burst_incr);
    end
    wait_done();
    check_value("rlast_count", rlast_count, 9);
    assert (saw_full)
      else abort_run("command queue never filled during back-to-back reads");
    random_rready = 1'b0;
  endtask

  task automatic test_error_window();
    // pieces at 0xdf80 and 0xdfc0 answer okay, 0xe000 and 0xe040 answer slverr
    issue_read(4'h2, 32'h0000_DF80, 8'd63, axi3_conv_pkg::burst_incr);
    issue_read(4'h1, 32'h0000_EFF0, 8'd3, axi3_conv_pkg::burst_fixed);
    wait_done();
    check_value("rlast_count", rlast_count, 11);
  endtask

  initial begin
    void'($urandom(32'h1c4d3b70));
    rst           = 1'b1;
    s_arid        = '0;
    s_araddr      = '0;
    s_arlen       = '0;
    s_arburst     = axi3_conv_pkg::burst_incr;
    s_arvalid     = 1'b0;
    cycle_count   = 0;
    rlast_count   = 0;
    saw_full      = 1'b0;
    random_rready = 1'b0;
    repeat (8) @(posedge aclk);
    #1;
    rst = 1'b0;
    test_short_incr();
    test_long_incr();
    test_incr_then_fixed();
    test_backpressure();
    test_error_window();
    $display("Simulation passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: sim.f
logic/axi3_conv_pkg.sv
logic/ar_axi3_split.sv
logic/split_cmd_fifo.sv
logic/r_axi3_merge.sv
logic/axi4_to_axi3_rd_conv.sv
tb/axi3_rd_slave.sv
tb/axi3_conv_assertions.sv
tb/tb_axi4_to_axi3_rd_conv.sv
